// ==== verilog.f ====
source/mrelbp_pkg.sv
source/ci_r6_controller.sv
source/ci_r6_window_sum.sv
source/ci_r6_compare.sv
source/ci_r6_top.sv
tb/ci_r6_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := ci_r6_tb
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Test passed

SOURCES   := $(shell cat $(FILELIST))
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# Pass or fail comes from the log, not the simulator exit code
run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/ci_r6_tb.sv ====
`timescale 1ns/1ps

module ci_r6_tb;

  import mrelbp_pkg::*;

  localparam int N_TESTS         = 6;
  localparam int N_RESULTS       = N_STRIPS * N_WIN_PER_STRIP;
  localparam int FRAME_COLS      = N_STRIPS * IMG_COLS;
  localparam int WATCHDOG_CYCLES = N_TESTS * FRAME_COLS * 4 + 200;

  logic       clk;
  logic       rst_n;
  logic       i_valid;
  pixel_col_t i_column;
  logic       o_valid;
  logic       o_ci;
  logic       o_frame_done;

  logic   win_col;  // Presented column completes a window
  pixel_t img [IMG_ROWS][IMG_COLS];
  logic   exp_bits [N_RESULTS];
  int     res_cnt;
  logic   exp_head;
  logic   exp_last;
  int     seed = 32'h49c2_124d;
  int     err_cnt;
  int     pass_cnt;
  int     fail_cnt;
  string  test_name;

  ci_r6_top dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_valid      (i_valid),
    .i_column     (i_column),
    .o_valid      (o_valid),
    .o_ci         (o_ci),
    .o_frame_done (o_frame_done)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // Results seen since the last reset
  always @(posedge clk) begin
    if (!rst_n) begin
      res_cnt <= 0;
    end else if (o_valid) begin
      res_cnt <= res_cnt + 1;
    end
  end

  assign exp_head = (res_cnt < N_RESULTS) ? exp_bits[res_cnt] : 1'b0;
  assign exp_last = (res_cnt == N_RESULTS - 1);

  assert property (@(posedge clk) disable iff (!rst_n) o_valid |-> (o_ci == exp_head))
  else begin
    err_cnt++;
    $display("FAIL %s: ci expected %0b actual %0b", test_name, $sampled(exp_head),
             $sampled(o_ci));
  end

  assert property (@(posedge clk) disable iff (!rst_n) o_valid |-> (res_cnt < N_RESULTS))
  else begin
    err_cnt++;
    $display("ERROR %s: more results than windows in the frame", test_name);
  end

  // Fixed 3-cycle latency from the accepted column
  assert property (@(posedge clk) disable iff (!rst_n) o_valid == $past(win_col, 3))
  else begin
    err_cnt++;
    $display("ERROR %s: o_valid not 3 cycles after a window-completing column", test_name);
  end

  assert property (@(posedge clk) disable iff (!rst_n) !$fell(o_frame_done))
  else begin
    err_cnt++;
    $display("ERROR %s: o_frame_done fell without a reset", test_name);
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    $rose(o_frame_done) |-> (o_valid && exp_last))
  else begin
    err_cnt++;
    $display("ERROR %s: o_frame_done did not rise with the last result", test_name);
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("ERROR: watchdog expired after %0d cycles in %s", WATCHDOG_CYCLES, test_name);
    $display("Test failed");
    $finish;
  end

  task automatic apply_reset();
    @(posedge clk);
    rst_n   <= 1'b0;
    i_valid <= 1'b0;
    win_col <= 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    assert (!o_valid && !o_frame_done) else begin
      err_cnt++;
      $display("ERROR %s: outputs not low after reset", test_name);
    end
  endtask

  task automatic fill_random();
    for (int r = 0; r < IMG_ROWS; r++) begin
      for (int c = 0; c < IMG_COLS; c++) begin
        img[r][c] = pixel_t'($random(seed));
      end
    end
  endtask

  task automatic fill_uniform(input pixel_t value);
    for (int r = 0; r < IMG_ROWS; r++) begin
      for (int c = 0; c < IMG_COLS; c++) begin
        img[r][c] = value;
      end
    end
  endtask

  // Every window center at 0, the rest at full scale
  task automatic fill_dark_centers();
    for (int r = 0; r < IMG_ROWS; r++) begin
      for (int c = 0; c < IMG_COLS; c++) begin
        if (r >= CENTER_IDX && r < CENTER_IDX + N_STRIPS &&
            c >= CENTER_IDX && c < CENTER_IDX + N_WIN_PER_STRIP) begin
          img[r][c] = 8'd0;
        end else begin
          img[r][c] = 8'd255;
        end
      end
    end
  endtask

  // Full 13x13 sum per window, straight from the image
  task automatic build_expected();
    int sum;
    int center;
    int idx;
    idx = 0;
    for (int s = 0; s < N_STRIPS; s++) begin
      for (int w = 0; w < N_WIN_PER_STRIP; w++) begin
        sum = 0;
        for (int r = 0; r < WIN; r++) begin
          for (int c = 0; c < WIN; c++) begin
            sum += int'(img[s+r][w+c]);
          end
        end
        center = int'(img[s+CENTER_IDX][w+CENTER_IDX]);
        exp_bits[idx] = (center * CI_SCALE >= sum);
        idx++;
      end
    end
  endtask

  task automatic stream_strips(input int n_strips, input bit gaps);
    pixel_col_t col;
    for (int s = 0; s < n_strips; s++) begin
      for (int c = 0; c < IMG_COLS; c++) begin
        if (gaps) begin
          while (($random(seed) & 3) == 0) begin
            @(posedge clk);
            i_valid <= 1'b0;
            win_col <= 1'b0;
          end
        end
        for (int k = 0; k < WIN; k++) begin
          col.px[k] = img[s+k][c];  // px[0] is the top row
        end
        @(posedge clk);
        i_valid  <= 1'b1;
        i_column <= col;
        win_col  <= (c >= WIN - 1);
      end
    end
    @(posedge clk);
    i_valid <= 1'b0;
    win_col <= 1'b0;
  endtask

  task automatic send_extra_columns(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      i_valid  <= 1'b1;
      i_column <= pixel_col_t'({WIN{pixel_t'($random(seed))}});
      win_col  <= 1'b0;
    end
    @(posedge clk);
    i_valid <= 1'b0;
  endtask

  task automatic wait_frame_done();
    while (!o_frame_done) begin
      @(posedge clk);
    end
  endtask

  task automatic check_count(input int expected);
    assert (res_cnt == expected) else begin
      err_cnt++;
      $display("FAIL %s: result count expected %0d actual %0d", test_name, expected, res_cnt);
    end
  endtask

  task automatic check_done_high();
    assert (o_frame_done) else begin
      err_cnt++;
      $display("ERROR %s: o_frame_done low at the end of the frame", test_name);
    end
  endtask

  task automatic run_frame(input bit gaps);
    apply_reset();
    build_expected();
    stream_strips(N_STRIPS, gaps);
    wait_frame_done();
    repeat (4) @(posedge clk);
    check_count(N_RESULTS);
    check_done_high();
  endtask

  task automatic report_test(input int err_before);
    if (err_cnt == err_before) begin
      pass_cnt++;
      $display("%s: ok, %0d results", test_name, res_cnt);
    end else begin
      fail_cnt++;
      $display("%s: %0d errors", test_name, err_cnt - err_before);
    end
  endtask

  initial begin
    int err_before;
    rst_n    = 1'b0;
    i_valid  = 1'b0;
    i_column = '0;
    win_col  = 1'b0;
    err_cnt  = 0;
    pass_cnt = 0;
    fail_cnt = 0;

    test_name  = "back_to_back";
    err_before = err_cnt;
    fill_random();
    run_frame(1'b0);
    report_test(err_before);

    test_name  = "idle_gaps";
    err_before = err_cnt;
    fill_random();
    run_frame(1'b1);
    report_test(err_before);

    test_name  = "uniform_tie";
    err_before = err_cnt;
    fill_uniform(8'd173);  // 173 * 169 equals the window sum
    run_frame(1'b0);
    report_test(err_before);

    test_name  = "dark_centers";
    err_before = err_cnt;
    fill_dark_centers();
    run_frame(1'b0);
    report_test(err_before);

    test_name  = "count_and_done";
    err_before = err_cnt;
    fill_random();
    run_frame(1'b0);
    send_extra_columns(IMG_COLS);  // Whole strip dropped in ST_DONE
    repeat (6) @(posedge clk);
    check_count(N_RESULTS);
    check_done_high();
    report_test(err_before);

    test_name  = "reset_restart";
    err_before = err_cnt;
    fill_random();
    apply_reset();
    build_expected();
    stream_strips(1, 1'b1);  // First strip only, then reset mid-frame
    repeat (6) @(posedge clk);
    check_count(N_WIN_PER_STRIP);
    fill_random();
    run_frame(1'b1);
    report_test(err_before);

    $display("%0d tests: %0d ok, %0d with errors, %0d errors total",
             N_TESTS, pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== source/ci_r6_top.sv ====
`timescale 1ns/1ps

module ci_r6_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   i_valid,
  input  mrelbp_pkg::pixel_col_t i_column,
  output logic                   o_valid,
  output logic                   o_ci,
  output logic                   o_frame_done
);

  import mrelbp_pkg::*;

  col_tag_t col_tag;  // Decode to execute
  win_res_t win_res;  // Execute to result

  ci_r6_controller u_controller (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_valid  (i_valid),
    .i_column (i_column),
    .o_tag    (col_tag)
  );

  ci_r6_window_sum u_window_sum (
    .clk   (clk),
    .rst_n (rst_n),
    .i_tag (col_tag),
    .o_res (win_res)
  );

  ci_r6_compare u_compare (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_res        (win_res),
    .o_valid      (o_valid),
    .o_ci         (o_ci),
    .o_frame_done (o_frame_done)
  );

endmodule

// ==== source/ci_r6_compare.sv ====
`timescale 1ns/1ps

module ci_r6_compare (
  input  logic                 clk,
  input  logic                 rst_n,
  input  mrelbp_pkg::win_res_t i_res,
  output logic                 o_valid,
  output logic                 o_ci,
  output logic                 o_frame_done
);

  import mrelbp_pkg::*;

  scaled_t  scaled_q;
  box_sum_t sum_q;
  logic     valid_q;
  logic     done_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      valid_q <= i_res.valid;
      if (i_res.valid && i_res.last) begin
        done_q <= 1'b1;  // Sticky until reset
      end
    end
  end

  always_ff @(posedge clk) begin
    scaled_q <= scaled_t'(i_res.center) * scaled_t'(CI_SCALE);
    sum_q    <= i_res.sum;
  end

  // Tie counts as 1
  assign o_ci         = (scaled_q >= sum_q);
  assign o_valid      = valid_q;
  assign o_frame_done = done_q;

endmodule

// ==== source/ci_r6_window_sum.sv ====
`timescale 1ns/1ps

module ci_r6_window_sum (
  input  logic                 clk,
  input  logic                 rst_n,
  input  mrelbp_pkg::col_tag_t i_tag,
  output mrelbp_pkg::win_res_t o_res
);

  import mrelbp_pkg::*;

  box_sum_t col_sum;
  box_sum_t col_hist [WIN];           // [0] newest previous column
  pixel_t   ctr_hist [CENTER_IDX];
  pixel_t   ctr_line [CENTER_IDX+1];  // [0] current column center
  box_sum_t run_sum;
  box_sum_t run_next;

  logic     res_valid;
  logic     res_last;
  box_sum_t res_sum;
  pixel_t   res_center;

  always_comb begin
    col_sum = '0;
    for (int i = 0; i < WIN; i++) begin
      col_sum = col_sum + box_sum_t'(i_tag.pixels.px[i]);
    end
  end

  always_comb begin
    ctr_line[0] = i_tag.pixels.px[CENTER_IDX];
    for (int i = 1; i <= CENTER_IDX; i++) begin
      ctr_line[i] = ctr_hist[i-1];
    end
  end

  always_comb begin
    if (i_tag.first) begin
      run_next = col_sum;
    end else if (i_tag.subtract) begin
      run_next = run_sum + col_sum - col_hist[WIN-1];  // Drop column k-13
    end else begin
      run_next = run_sum + col_sum;
    end
  end

  // Histories and running sum move only on valid columns
  always_ff @(posedge clk) begin
    if (i_tag.valid) begin
      run_sum     <= run_next;
      col_hist[0] <= col_sum;
      for (int i = 1; i < WIN; i++) begin
        col_hist[i] <= col_hist[i-1];
      end
      for (int i = 0; i < CENTER_IDX; i++) begin
        ctr_hist[i] <= ctr_line[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_valid <= 1'b0;
      res_last  <= 1'b0;
    end else begin
      res_valid <= i_tag.valid && i_tag.window;
      res_last  <= i_tag.valid && i_tag.window && i_tag.last;
    end
  end

  always_ff @(posedge clk) begin
    res_sum    <= run_next;
    res_center <= ctr_line[CENTER_IDX];  // Center column is k-6
  end

  assign o_res.valid  = res_valid;
  assign o_res.last   = res_last;
  assign o_res.sum    = res_sum;
  assign o_res.center = res_center;

endmodule

// ==== source/ci_r6_controller.sv ====
`timescale 1ns/1ps

module ci_r6_controller (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   i_valid,
  input  mrelbp_pkg::pixel_col_t i_column,
  output mrelbp_pkg::col_tag_t   o_tag
);

  import mrelbp_pkg::*;

  ctl_state_t state_q;
  ctl_state_t state_d;
  col_idx_t   col_cnt;
  strip_idx_t strip_cnt;

  logic       accept;
  logic       col_wrap;
  logic       frame_end;

  logic       tag_valid;
  logic       tag_first;
  logic       tag_subtract;
  logic       tag_window;
  logic       tag_last;
  pixel_col_t tag_pixels;

  assign accept    = i_valid && (state_q != ST_DONE);
  assign col_wrap  = (col_cnt == col_idx_t'(IMG_COLS - 1));
  assign frame_end = col_wrap && (strip_cnt == strip_idx_t'(N_STRIPS - 1));

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (accept) begin
          state_d = ST_RUN;
        end
      end
      ST_RUN: begin
        if (accept && frame_end) begin
          state_d = ST_DONE;
        end
      end
      ST_DONE: begin
        state_d = ST_DONE;  // Held until reset
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q   <= ST_IDLE;
      col_cnt   <= '0;
      strip_cnt <= '0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        if (col_wrap) begin
          col_cnt   <= '0;
          strip_cnt <= frame_end ? '0 : strip_cnt + 1'b1;
        end else begin
          col_cnt <= col_cnt + 1'b1;
        end
      end
    end
  end

  // Position flags come from the counters before they advance
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tag_valid    <= 1'b0;
      tag_first    <= 1'b0;
      tag_subtract <= 1'b0;
      tag_window   <= 1'b0;
      tag_last     <= 1'b0;
    end else begin
      tag_valid    <= accept;
      tag_first    <= (col_cnt == '0);
      tag_subtract <= (col_cnt >= col_idx_t'(WIN));
      tag_window   <= (col_cnt >= col_idx_t'(WIN - 1));
      tag_last     <= frame_end;
    end
  end

  always_ff @(posedge clk) begin
    tag_pixels <= i_column;
  end

  assign o_tag.valid    = tag_valid;
  assign o_tag.first    = tag_first;
  assign o_tag.subtract = tag_subtract;
  assign o_tag.window   = tag_window;
  assign o_tag.last     = tag_last;
  assign o_tag.pixels   = tag_pixels;

endmodule

// ==== source/mrelbp_pkg.sv ====
package mrelbp_pkg;

  localparam int IMG_COLS        = 15;
  localparam int IMG_ROWS        = 15;
  localparam int WIN             = 13;
  localparam int CENTER_IDX      = 6;
  localparam int CI_SCALE        = 169;  // WIN * WIN
  localparam int N_STRIPS        = IMG_ROWS - 12;
  localparam int N_WIN_PER_STRIP = IMG_COLS - 12;

  typedef logic [7:0]  pixel_t;
  typedef logic [15:0] box_sum_t;   // Max window sum 43095
  typedef logic [15:0] scaled_t;
  typedef logic [9:0]  col_idx_t;
  typedef logic [9:0]  strip_idx_t;

  // px[0] is the top row, px[CENTER_IDX] the center
  typedef struct packed {
    pixel_t [WIN-1:0] px;
  } pixel_col_t;

  typedef struct packed {
    logic       valid;
    logic       first;
    logic       subtract;  // Oldest column leaves the window
    logic       window;    // Full window present
    logic       last;
    pixel_col_t pixels;
  } col_tag_t;

  typedef struct packed {
    logic     valid;
    logic     last;
    box_sum_t sum;
    pixel_t   center;
  } win_res_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_DONE
  } ctl_state_t;

endpackage
